// ==== pipeControl.f ====
source/pipePkg.sv
source/hazard.sv
source/fetchUnit.sv
source/pipeStage.sv
source/retireUnit.sv
source/pipeControl.sv
tests/pipeControlTb.sv

// ==== tests/pipeControlTb.sv ====
/*
 * Pipeline control testbench
 * Drives the hazard causes from a stimulus table and from random rows and
 * checks stall, flush and retirement against a cycle model of the pipeline
 */

`timescale 1ns/1ps

module pipeControlTb;

  import pipePkg::*;

  typedef logic [19:0] causeT;

  // Each hazard cause owns one bit in the order the inputs are unpacked below
  localparam causeT mBp = 20'h00001, mCsr = 20'h00002, mRet = 20'h00004, mTrap = 20'h00008,
                    mLoad = 20'h00010, mStore = 20'h00020, mFpu = 20'h00100,
                    mLsu = 20'h00400, mIfu = 20'h00800, mDiv = 20'h01000,
                    mEcall = 20'h04000, mBreak = 20'h08000, mFence = 20'h10000,
                    mSfence = 20'h20000, mWfi = 20'h40000, mInt = 20'h80000;

  localparam int maxRows = 32;
  localparam int numRandom = 60;
  localparam pcT brPc = 32'h8000_2000;
  localparam pcT retPc = 32'h8000_0040;
  localparam pcT fncPc = 32'h8000_3000;

  logic clk = 1'b0;
  logic rstN;
  logic bpPredWrongE, csrWritePendingDEM, retM, trapM;
  logic loadStallD, storeStallD, mduStallD, csrRdStallD, fpuStallD, fStallD;
  logic lsuStallM, ifuStallF, divBusyE, fDivBusyE, ecallFaultM, breakpointFaultM;
  logic invalidateICacheM, sfencevmaM, wfiM, intPendingM;
  pcT branchTarget, retTarget, fenceTarget;
  stageVecT stall, flush;
  logic retireValid;
  pcT retirePc;
  logic [31:0] retireCount;

  // Stimulus table with one entry per row
  string rowName [maxRows];
  causeT rowCause [maxRows];
  pcT rowBranch [maxRows];
  pcT rowRet [maxRows];
  pcT rowFence [maxRows];
  int rowRepeat [maxRows];
  int numRows = 0;

  // Model tokens where entry 0 is the fetch slot and the last entry is W
  pcT tokPc [numStages+1];
  logic tokValid [numStages+1];
  logic [31:0] modelCount;

  int valueErrors = 0;
  int retireErrors = 0;
  int cycleCount = 0;
  int cycleLimit;

  pipeControl pipeControl_inst (.*);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic driveInputs(input causeT c, input pcT bt, input pcT rt, input pcT ft);
    {intPendingM, wfiM, sfencevmaM, invalidateICacheM, breakpointFaultM, ecallFaultM,
     fDivBusyE, divBusyE, ifuStallF, lsuStallM, fStallD, fpuStallD, csrRdStallD, mduStallD,
     storeStallD, loadStallD, trapM, retM, csrWritePendingDEM, bpPredWrongE} = c;
    branchTarget = bt;
    retTarget = rt;
    fenceTarget = ft;
  endtask

  task automatic addRow(input string name, input causeT c, input pcT bt, input pcT rt,
                        input pcT ft, input int reps);
    rowName[numRows] = name;
    rowCause[numRows] = c;
    rowBranch[numRows] = bt;
    rowRet[numRows] = rt;
    rowFence[numRows] = ft;
    rowRepeat[numRows] = reps;
    numRows++;
  endtask

  // Each cause is raised with a probability of one in eight
  function automatic causeT randomCauses();
    causeT c;
    c = '0;
    for (int b = 0; b < 20; b++) begin
      if ($urandom_range(7) == 0) begin
        c[b] = 1'b1;
      end
    end
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Stall and flush follow from the causes currently driven
  task automatic predictHazard(output stageVecT s, output stageVecT f);
    stageVecT cause;
    logic redirect;
    redirect = trapM | retM | bpPredWrongE;
    // Causes in F and D are moot when the PC is about to change
    cause[idxF] = csrWritePendingDEM & ~redirect;
    cause[idxD] = (loadStallD | storeStallD | mduStallD | csrRdStallD | fpuStallD | fStallD) &
                  ~redirect;
    cause[idxE] = (divBusyE | fDivBusyE) & ~trapM;
    cause[idxM] = wfiM & ~intPendingM & ~trapM;
    cause[idxW] = lsuStallM | ifuStallF;
    s[idxW] = cause[idxW];
    for (int i = idxM; i >= idxF; i--) begin
      s[i] = cause[i] | s[i+1];
    end
    // The first stage still moving behind a stall takes a bubble
    f = '0;
    for (int i = idxD; i <= idxW; i++) begin
      f[i] = s[i-1] & ~s[i];
    end
    if (trapM || retM || invalidateICacheM) begin
      f[idxM:idxD] = 3'b111;
    end
    if (bpPredWrongE) begin
      f[idxE:idxF] = 3'b111;
    end
    f[idxF] = f[idxF] | invalidateICacheM;
    // Ecall and ebreak still write back
    f[idxW] = f[idxW] | (trapM & ~ecallFaultM & ~breakpointFaultM);
  endtask

  // One rising edge of the model pipeline
  task automatic advanceModel(input stageVecT s, input stageVecT f);
    pcT nextPc;
    if (tokValid[idxW] && !s[idxW]) begin
      modelCount = modelCount + 1;
    end
    // Oldest stage first so each one still sees its old input
    for (int i = numStages; i >= 1; i--) begin
      if (f[i]) begin
        tokValid[i] = 1'b0;
      end else if (!s[i]) begin
        tokValid[i] = tokValid[i-1];
        tokPc[i] = tokPc[i-1];
      end
    end
    if (trapM) begin
      nextPc = trapVector;
    end else if (retM) begin
      nextPc = retTarget;
    end else if (bpPredWrongE) begin
      nextPc = branchTarget;
    end else if (invalidateICacheM) begin
      nextPc = fenceTarget;
    end else if (tokValid[idxF] && !s[idxF]) begin
      nextPc = tokPc[idxF] + pcStep;
    end else begin
      nextPc = tokPc[idxF];
    end
    tokPc[idxF] = nextPc;
    tokValid[idxF] = ~f[idxF];
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic checkVec(input string name, input string what, input stageVecT exp,
                          input stageVecT act);
    if (act !== exp) begin
      $display("Error %s %s: expected %b, actual %b", name, what, exp, act);
      valueErrors++;
    end
  endtask

  task automatic checkPc(input string name, input pcT exp, input pcT act);
    if (act !== exp) begin
      $display("Error %s retirePc: expected %h, actual %h", name, exp, act);
      valueErrors++;
    end
  endtask

  task automatic checkCount(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error %s retireCount: expected %0d, actual %0d", name, exp, act);
      valueErrors++;
    end
  endtask

  // Entered on a falling edge and left on the next one
  task automatic runCycle(input string name, input causeT c, input pcT bt, input pcT rt,
                          input pcT ft);
    stageVecT expStall;
    stageVecT expFlush;
    logic expRetire;
    driveInputs(c, bt, rt, ft);
    predictHazard(expStall, expFlush);
    expRetire = tokValid[idxW] & ~expStall[idxW];
    #5;
    checkVec(name, "stall", expStall, stall);
    checkVec(name, "flush", expFlush, flush);
    if (expRetire && retireValid !== 1'b1) begin
      $display("Test %s: the token in W should retire but retireValid is low", name);
      retireErrors++;
    end else if (!expRetire && retireValid !== 1'b0) begin
      $display("Test %s: retireValid is high with nothing to retire", name);
      retireErrors++;
    end else if (expRetire) begin
      checkPc(name, tokPc[idxW], retirePc);
    end
    checkCount(name, modelCount, retireCount);
    @(posedge clk);
    advanceModel(expStall, expFlush);
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the stimulus did not complete", cycleCount);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(92));
    rstN = 1'b0;
    driveInputs('0, '0, '0, '0);
    modelCount = '0;
    for (int i = 0; i <= numStages; i++) begin
      tokValid[i] = 1'b0;
      tokPc[i] = resetPc;
    end
    addRow("stream", '0, brPc, retPc, fncPc, 12);
    addRow("loadStall", mLoad, brPc, retPc, fncPc, 3);
    addRow("divBusy", mDiv, brPc, retPc, fncPc, 3);
    addRow("wfiSleep", mWfi, brPc, retPc, fncPc, 3);
    addRow("lsuStall", mLsu, brPc, retPc, fncPc, 3);
    addRow("drain", '0, brPc, retPc, fncPc, 4);
    addRow("mispredict", mBp | mLoad | mCsr, brPc, retPc, fncPc, 1);
    addRow("afterBranch", '0, brPc, retPc, fncPc, 6);
    addRow("trapEcall", mTrap | mEcall, brPc, retPc, fncPc, 1);
    addRow("afterEcall", '0, brPc, retPc, fncPc, 5);
    addRow("trapPlain", mTrap | mDiv, brPc, retPc, fncPc, 1);
    addRow("afterTrap", '0, brPc, retPc, fncPc, 5);
    addRow("trapBreak", mTrap | mBreak, brPc, retPc, fncPc, 1);
    addRow("return", mRet, brPc, retPc, fncPc, 1);
    addRow("afterReturn", '0, brPc, retPc, fncPc, 6);
    addRow("fence", mFence, brPc, retPc, fncPc, 1);
    addRow("afterFence", '0, brPc, retPc, fncPc, 5);
    addRow("sfenceOnly", mSfence, brPc, retPc, fncPc, 3);
    addRow("wfiWake", mWfi | mInt, brPc, retPc, fncPc, 2);
    addRow("csrPending", mCsr, brPc, retPc, fncPc, 3);
    addRow("ifuStall", mIfu | mStore | mFpu, brPc, retPc, fncPc, 2);
    addRow("drainEnd", '0, brPc, retPc, fncPc, 6);
    // Reset cycles fit inside the margin of 20
    cycleLimit = numRandom + 20;
    for (int r = 0; r < numRows; r++) begin
      cycleLimit += rowRepeat[r];
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    for (int r = 0; r < numRows; r++) begin
      for (int k = 0; k < rowRepeat[r]; k++) begin
        runCycle(rowName[r], rowCause[r], rowBranch[r], rowRet[r], rowFence[r]);
      end
    end
    for (int k = 0; k < numRandom; k++) begin
      runCycle($sformatf("random%0d", k), randomCauses(), $urandom & 32'hFFFF_FFFC,
               $urandom & 32'hFFFF_FFFC, $urandom & 32'hFFFF_FFFC);
    end
    $display("Checks finished with %0d value errors and %0d retirement errors",
             valueErrors, retireErrors);
    if (valueErrors + retireErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== source/pipeControl.sv ====
/*
 * Pipeline control top level
 * Wires the hazard unit, the fetch unit, the D to W token registers and the
 * retire unit into a five-stage in-order pipeline skeleton
 */

`timescale 1ns/1ps

module pipeControl (
  input  logic               clk,
  input  logic               rstN,
  // Hazard causes
  input  logic               bpPredWrongE,
  input  logic               csrWritePendingDEM,
  input  logic               retM,
  input  logic               trapM,
  input  logic               loadStallD,
  input  logic               storeStallD,
  input  logic               mduStallD,
  input  logic               csrRdStallD,
  input  logic               fpuStallD,
  input  logic               fStallD,
  input  logic               lsuStallM,
  input  logic               ifuStallF,
  input  logic               divBusyE,
  input  logic               fDivBusyE,
  input  logic               ecallFaultM,
  input  logic               breakpointFaultM,
  input  logic               invalidateICacheM,
  input  logic               sfencevmaM,
  input  logic               wfiM,
  input  logic               intPendingM,
  // Redirect targets
  input  pipePkg::pcT        branchTarget,
  input  pipePkg::pcT        retTarget,
  input  pipePkg::pcT        fenceTarget,
  // Stage control and retirement
  output pipePkg::stageVecT  stall,
  output pipePkg::stageVecT  flush,
  output logic               retireValid,
  output pipePkg::pcT        retirePc,
  output logic [31:0]        retireCount
);

  import pipePkg::*;

  // Token chain where entry 0 is the fetch slot and the last entry is W
  pcT   pcS    [numStages+1];
  logic validS [numStages+1];

  //////////////////////////////////////////////////
  // Hazard unit
  //////////////////////////////////////////////////

  hazard uHazard (
    .bpPredWrongE      (bpPredWrongE),
    .csrWritePendingDEM(csrWritePendingDEM),
    .retM              (retM),
    .trapM             (trapM),
    .loadStallD        (loadStallD),
    .storeStallD       (storeStallD),
    .mduStallD         (mduStallD),
    .csrRdStallD       (csrRdStallD),
    .fpuStallD         (fpuStallD),
    .fStallD           (fStallD),
    .lsuStallM         (lsuStallM),
    .ifuStallF         (ifuStallF),
    .divBusyE          (divBusyE),
    .fDivBusyE         (fDivBusyE),
    .ecallFaultM       (ecallFaultM),
    .breakpointFaultM  (breakpointFaultM),
    .invalidateICacheM (invalidateICacheM),
    .sfencevmaM        (sfencevmaM),
    .wfiM              (wfiM),
    .intPendingM       (intPendingM),
    .stallF            (stall[idxF]),
    .stallD            (stall[idxD]),
    .stallE            (stall[idxE]),
    .stallM            (stall[idxM]),
    .stallW            (stall[idxW]),
    .flushF            (flush[idxF]),
    .flushD            (flush[idxD]),
    .flushE            (flush[idxE]),
    .flushM            (flush[idxM]),
    .flushW            (flush[idxW])
  );

  //////////////////////////////////////////////////
  // Fetch and token registers
  //////////////////////////////////////////////////

  fetchUnit uFetch (
    .clk              (clk),
    .rstN             (rstN),
    .stallF           (stall[idxF]),
    .flushF           (flush[idxF]),
    .trapM            (trapM),
    .retM             (retM),
    .bpPredWrongE     (bpPredWrongE),
    .invalidateICacheM(invalidateICacheM),
    .branchTarget     (branchTarget),
    .retTarget        (retTarget),
    .fenceTarget      (fenceTarget),
    .pcF              (pcS[0]),
    .validF           (validS[0])
  );

  // Register i sits in front of stage i+1, so it takes that stage's control
  for (genvar i = 0; i < numStages; i++) begin : genStage
    pipeStage uStage (
      .clk     (clk),
      .rstN    (rstN),
      .stall   (stall[i+1]),
      .flush   (flush[i+1]),
      .pcIn    (pcS[i]),
      .validIn (validS[i]),
      .pcOut   (pcS[i+1]),
      .validOut(validS[i+1])
    );
  end

  //////////////////////////////////////////////////
  // Retirement
  //////////////////////////////////////////////////

  retireUnit uRetire (
    .clk        (clk),
    .rstN       (rstN),
    .stallW     (stall[idxW]),
    .pcW        (pcS[numStages]),
    .validW     (validS[numStages]),
    .retireValid(retireValid),
    .retirePc   (retirePc),
    .retireCount(retireCount)
  );

endmodule

// ==== source/retireUnit.sv ====
/*
 * Retire unit
 * Drains the writeback register, flags each retiring instruction with its
 * PC and keeps a running count of retirements
 */

`timescale 1ns/1ps

module retireUnit (
  input  logic         clk,
  input  logic         rstN,
  input  logic         stallW,
  input  pipePkg::pcT  pcW,
  input  logic         validW,
  output logic         retireValid,
  output pipePkg::pcT  retirePc,
  output logic [31:0]  retireCount
);

  //////////////////////////////////////////////////
  // Retirement
  //////////////////////////////////////////////////

  // A token held in W by a stall retires only on the cycle it leaves
  assign retireValid = validW & ~stallW;

  // The address is only meaningful while retireValid is high
  assign retirePc = pcW;

  //////////////////////////////////////////////////
  // Retirement counter
  //////////////////////////////////////////////////

  // Wraps silently after 2^32 instructions
  always_ff @(posedge clk) begin
    if (!rstN) begin
      retireCount <= '0;
    end else if (retireValid) begin
      retireCount <= retireCount + 32'd1;
    end
  end

endmodule

// ==== source/pipeStage.sv ====
/*
 * Pipeline stage register
 * Carries one instruction token between stages, holding it on stall and
 * squashing it on flush
 */

`timescale 1ns/1ps

module pipeStage (
  input  logic         clk,
  input  logic         rstN,
  input  logic         stall,
  input  logic         flush,
  input  pipePkg::pcT  pcIn,
  input  logic         validIn,
  output pipePkg::pcT  pcOut,
  output logic         validOut
);

  // Valid bit of the token
  // Flush wins over stall so a squashed token never lingers
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validOut <= 1'b0;
    end else if (flush) begin
      validOut <= 1'b0;
    end else if (!stall) begin
      validOut <= validIn;
    end
  end

  // Token address
  // On flush the old PC stays visible as the squashed instruction
  always_ff @(posedge clk) begin
    if (!flush && !stall) begin
      pcOut <= pcIn;
    end
  end

endmodule

// ==== source/fetchUnit.sv ====
/*
 * Fetch unit
 * Holds the fetch PC and its valid bit and picks the next PC from the
 * trap, return, branch and fence redirects or the sequential step
 */

`timescale 1ns/1ps

module fetchUnit (
  input  logic         clk,
  input  logic         rstN,
  input  logic         stallF,
  input  logic         flushF,
  input  logic         trapM,
  input  logic         retM,
  input  logic         bpPredWrongE,
  input  logic         invalidateICacheM,
  input  pipePkg::pcT  branchTarget,
  input  pipePkg::pcT  retTarget,
  input  pipePkg::pcT  fenceTarget,
  output pipePkg::pcT  pcF,
  output logic         validF
);

  import pipePkg::*;

  pcT nextPc;

  //////////////////////////////////////////////////
  // Next PC selection
  //////////////////////////////////////////////////

  // Redirects win over a stall in the order trap, return, branch and fence
  // An empty fetch slot keeps its PC so the address is not skipped
  always_comb begin
    if (trapM) begin
      nextPc = trapVector;
    end else if (retM) begin
      nextPc = retTarget;
    end else if (bpPredWrongE) begin
      nextPc = branchTarget;
    end else if (invalidateICacheM) begin
      nextPc = fenceTarget;
    end else if (validF && !stallF) begin
      nextPc = pcF + pcStep;
    end else begin
      nextPc = pcF;
    end
  end

  //////////////////////////////////////////////////
  // PC and valid registers
  //////////////////////////////////////////////////

  // The slot goes valid on the first edge after reset
  // A flush empties it for one cycle while the new PC is loaded
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF    <= resetPc;
      validF <= 1'b0;
    end else begin
      pcF    <= nextPc;
      validF <= ~flushF;
    end
  end

endmodule

// ==== source/hazard.sv ====
/*
 * Hazard unit
 * Turns the per-stage stall causes and the redirect events into a stall
 * and a flush for every pipeline stage with purely combinational logic
 */

`timescale 1ns/1ps

module hazard (
  // Redirects and privileged events
  input  logic bpPredWrongE,
  input  logic csrWritePendingDEM,
  input  logic retM,
  input  logic trapM,
  // Decode stall causes
  input  logic loadStallD,
  input  logic storeStallD,
  input  logic mduStallD,
  input  logic csrRdStallD,
  input  logic fpuStallD,
  input  logic fStallD,
  // Memory system stalls
  input  logic lsuStallM,
  input  logic ifuStallF,
  // Long-latency execute units
  input  logic divBusyE,
  input  logic fDivBusyE,
  // Trap qualifiers
  input  logic ecallFaultM,
  input  logic breakpointFaultM,
  // Fences and wait for interrupt
  input  logic invalidateICacheM,
  input  logic sfencevmaM,
  input  logic wfiM,
  input  logic intPendingM,
  // Per-stage control
  output logic stallF,
  output logic stallD,
  output logic stallE,
  output logic stallM,
  output logic stallW,
  output logic flushF,
  output logic flushD,
  output logic flushE,
  output logic flushM,
  output logic flushW
);

  logic redirectMask;
  logic stallFCause, stallDCause, stallECause, stallMCause, stallWCause;
  logic firstUnstalledD, firstUnstalledE, firstUnstalledM, firstUnstalledW;
  logic fence, privilegedFlush;

  //////////////////////////////////////////////////
  // Stall causes
  //////////////////////////////////////////////////

  // A trap, a return or a mispredict changes the PC, so the younger
  // instructions waiting in F and D are about to be squashed anyway
  assign redirectMask = trapM | retM | bpPredWrongE;

  // Fetch waits behind an outstanding CSR write
  assign stallFCause = csrWritePendingDEM & ~redirectMask;
  assign stallDCause = (loadStallD | storeStallD | mduStallD | csrRdStallD |
                        fpuStallD | fStallD) & ~redirectMask;
  // A trap abandons the divide in flight
  assign stallECause = (divBusyE | fDivBusyE) & ~trapM;
  // WFI sleeps in M until any interrupt becomes pending or a trap is taken
  assign stallMCause = wfiM & ~trapM & ~intPendingM;
  assign stallWCause = lsuStallM | ifuStallF;

  //////////////////////////////////////////////////
  // Stall chain
  //////////////////////////////////////////////////

  // A stage cannot move while the stage ahead of it is stalled
  assign stallW = stallWCause;
  assign stallM = stallMCause | stallW;
  assign stallE = stallECause | stallM;
  assign stallD = stallDCause | stallE;
  assign stallF = stallFCause | stallD;

  // The oldest stage still moving receives a bubble behind the stall
  assign firstUnstalledD = ~stallD & stallF;
  assign firstUnstalledE = ~stallE & stallD;
  assign firstUnstalledM = ~stallM & stallE;
  assign firstUnstalledW = ~stallW & stallM;

  //////////////////////////////////////////////////
  // Flushes
  //////////////////////////////////////////////////

  // Only the instruction cache invalidate restarts fetch here
  // sfence.vma is accepted at the port but does not yet flush
  assign fence           = invalidateICacheM;
  assign privilegedFlush = trapM | retM | fence;

  assign flushF = bpPredWrongE | fence;
  assign flushD = firstUnstalledD | privilegedFlush | bpPredWrongE;
  assign flushE = firstUnstalledE | privilegedFlush | bpPredWrongE;
  assign flushM = firstUnstalledM | privilegedFlush;
  // An ecall or ebreak in M still writes back while any other trap kills it
  assign flushW = firstUnstalledW | (trapM & ~(breakpointFaultM | ecallFaultM));

endmodule

// ==== source/pipePkg.sv ====
/*
 * Pipeline package
 * Program counter and stage-vector types together with the constants
 * shared by the fetch unit, the stage registers and the top level
 */

package pipePkg;

  //////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////

  // Width of every program counter in the pipeline
  localparam int pcWidth = 32;

  typedef logic [pcWidth-1:0] pcT;

  // First instruction fetched once reset is released
  localparam pcT resetPc = 32'h8000_0000;

  // Machine trap handler entry point
  localparam pcT trapVector = 32'h8000_0100;

  // Sequential fetch advances by one 32-bit instruction
  localparam pcT pcStep = 32'd4;

  //////////////////////////////////////////////////
  // Stage vectors
  //////////////////////////////////////////////////

  // Token registers after fetch, which are D, E, M and W
  localparam int numStages = 4;

  // One bit per stage with F at the bottom and W at the top
  typedef logic [numStages:0] stageVecT;

  // Bit positions inside a stage vector
  localparam int idxF = 0;
  localparam int idxD = 1;
  localparam int idxE = 2;
  localparam int idxM = 3;
  localparam int idxW = 4;

endpackage
